// ==== src/hps_io_pkg.sv ====
/*
 * shared widths, command codes and bus word type for the host command channel
 * import into any block that decodes host words or sizes its ports from these
 */

package hps_io_pkg;

	localparam int IO_W      = 16;
	localparam int JOY_W     = 32;
	localparam int STATUS_W  = 64;
	localparam int CFG_W     = 16;
	localparam int CNT_W     = 9;
	localparam int ADDR_W    = 27;
	localparam int DATA_W    = 8;
	localparam int KEY_W     = 11;
	localparam int REQ_CNT_W = 4;

	// one word on the host parallel bus
	typedef logic [IO_W-1:0] io_word_t;

	////////////////////
	// user-I/O commands
	localparam io_word_t CMD_CFG        = 16'h0001;
	localparam io_word_t CMD_JOY0       = 16'h0002;
	localparam io_word_t CMD_JOY1       = 16'h0003;
	localparam io_word_t CMD_KBD        = 16'h0005;
	localparam io_word_t CMD_STATUS     = 16'h001E;
	localparam io_word_t CMD_STATUS_REQ = 16'h0029;

	// tag in the upper nibble of the status request readback
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	////////////////////
	// file transfer commands
	localparam io_word_t FIO_FILE_TX     = 16'h0053;
	localparam io_word_t FIO_FILE_TX_DAT = 16'h0054;
	localparam io_word_t FIO_FILE_INDEX  = 16'h0055;

	// start word low byte that means upload, not served here
	localparam logic [7:0] FIO_TX_UPLOAD = 8'hAA;

	////////////////////
	// keyboard
	localparam logic [7:0] SKIP_PREFIX = 8'hFF;
	localparam logic [7:0] KEY_BREAK   = 8'hF0;
	localparam logic [7:0] KEY_EXT     = 8'hE0;

	// raw four-byte histories that get a replacement code
	localparam logic [31:0] PRTSCR_MAKE_SEQ   = 32'hE012E07C;
	localparam logic [9:0]  PRTSCR_MAKE_CODE  = 10'h37C;
	localparam logic [31:0] PRTSCR_BREAK_SEQ  = 32'h7CE0F012;
	localparam logic [9:0]  PRTSCR_BREAK_CODE = 10'h17C;
	localparam logic [31:0] PAUSE_MAKE_SEQ    = 32'hF014F077;
	localparam logic [9:0]  PAUSE_MAKE_CODE   = 10'h377;

endpackage

// ==== src/uio_cmd_decoder.sv ====
/*
 * user-I/O command path: word counter, command latch, register writes
 * and the registered readback word, plus keyboard control pulses
 */

`timescale 1ns/100ps

module uio_cmd_decoder (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic                                 io_strobe,
	input  logic                                 io_enable,
	input  hps_io_pkg::io_word_t                 io_din,
	output hps_io_pkg::io_word_t                 io_dout,
	output logic [hps_io_pkg::CFG_W-1:0]         cfg,
	output logic [hps_io_pkg::JOY_W-1:0]         joystick_0,
	output logic [hps_io_pkg::JOY_W-1:0]         joystick_1,
	output logic [hps_io_pkg::STATUS_W-1:0]      status,
	input  logic [hps_io_pkg::REQ_CNT_W-1:0]     req_count,
	input  logic [hps_io_pkg::STATUS_W-1:0]      status_req,
	output logic [7:0]                           key_byte,
	output logic                                 key_shift,
	output logic                                 key_clear,
	output logic                                 key_commit
);

	import hps_io_pkg::*;

	logic [CNT_W-1:0] byte_cnt;
	io_word_t         cmd;
	logic             ps2skip;
	logic             cmd_phase;
	logic             arg_strobe;
	logic             skip_word;

	assign cmd_phase  = (byte_cnt == '0);
	assign arg_strobe = io_enable & io_strobe & ~cmd_phase;
	assign skip_word  = (io_din[15:8] == SKIP_PREFIX);

	////////////////////
	// keyboard control

	assign key_byte   = io_din[7:0];
	assign key_clear  = io_enable & io_strobe & cmd_phase & (io_din == CMD_KBD);
	assign key_shift  = arg_strobe & (cmd == CMD_KBD) & ~skip_word & ~ps2skip;
	// cmd still holds 0x05 in the first idle cycle and is cleared at its end
	assign key_commit = ~io_enable & (cmd == CMD_KBD) & ~ps2skip;

	////////////////////
	// transaction tracking and readback

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			byte_cnt <= '0;
			cmd      <= '0;
			ps2skip  <= 1'b0;
			io_dout  <= '0;
		end else if (!io_enable) begin
			byte_cnt <= '0;
			cmd      <= '0;
			ps2skip  <= 1'b0;
			io_dout  <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			// saturate so long transactions never wrap back to the command slot
			if (~&byte_cnt) begin
				byte_cnt <= byte_cnt + 1'b1;
			end

			if (cmd_phase) begin
				cmd <= io_din;
				if (io_din == CMD_STATUS_REQ) begin
					io_dout <= {8'h00, STATUS_REQ_TAG, req_count};
				end
			end else begin
				if (cmd == CMD_KBD && skip_word) begin
					ps2skip <= 1'b1;
				end
				if (cmd == CMD_STATUS_REQ) begin
					case (byte_cnt)
						CNT_W'(1): io_dout <= status_req[15:0];
						CNT_W'(2): io_dout <= status_req[31:16];
						CNT_W'(3): io_dout <= status_req[47:32];
						CNT_W'(4): io_dout <= status_req[63:48];
						default:   io_dout <= '0;
					endcase
				end
			end
		end
	end

	////////////////////
	// register writes

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (arg_strobe) begin
			case (cmd)
				CMD_CFG: begin
					cfg <= io_din;
				end
				// low half first, then high half
				CMD_JOY0: begin
					if (byte_cnt == CNT_W'(1)) begin
						joystick_0[15:0] <= io_din;
					end else if (byte_cnt == CNT_W'(2)) begin
						joystick_0[31:16] <= io_din;
					end
				end
				CMD_JOY1: begin
					if (byte_cnt == CNT_W'(1)) begin
						joystick_1[15:0] <= io_din;
					end else if (byte_cnt == CNT_W'(2)) begin
						joystick_1[31:16] <= io_din;
					end
				end
				CMD_STATUS: begin
					case (byte_cnt)
						CNT_W'(1): status[15:0]  <= io_din;
						CNT_W'(2): status[31:16] <= io_din;
						CNT_W'(3): status[47:32] <= io_din;
						CNT_W'(4): status[63:48] <= io_din;
						default: begin
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== src/status_request.sv ====
/*
 * core-to-host status request capture
 * counts rising edges of status_set and holds the word sent with the latest one
 */

`timescale 1ns/100ps

module status_request (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic                                 status_set,
	input  logic [hps_io_pkg::STATUS_W-1:0]      status_in,
	output logic [hps_io_pkg::REQ_CNT_W-1:0]     req_count,
	output logic [hps_io_pkg::STATUS_W-1:0]      status_req
);

	logic status_set_d;
	logic set_rise;

	assign set_rise = status_set & ~status_set_d;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_d <= 1'b0;
			req_count    <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			// counter wraps, the host only looks for a change
			if (set_rise) begin
				req_count  <= req_count + 1'b1;
				status_req <= status_in;
			end
		end
	end

endmodule

// ==== src/ps2_key_decoder.sv ====
/*
 * PS/2 scan-code assembly
 * keeps the last four bytes of a keyboard transaction and forms the key event
 */

`timescale 1ns/100ps

module ps2_key_decoder (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic [7:0]                           key_byte,
	input  logic                                 key_shift,
	input  logic                                 key_clear,
	input  logic                                 key_commit,
	output logic [hps_io_pkg::KEY_W-1:0]         ps2_key
);

	import hps_io_pkg::*;

	// newest byte in the low eight bits
	logic [31:0] key_raw;
	logic        pressed;
	logic        extended;

	assign pressed  = (key_raw[15:8] != KEY_BREAK);
	// on a break the prefix sits in front of the F0
	assign extended = pressed ? (key_raw[15:8] == KEY_EXT) : (key_raw[23:16] == KEY_EXT);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			key_raw <= '0;
		end else if (key_clear) begin
			key_raw <= '0;
		end else if (key_shift) begin
			key_raw <= {key_raw[23:0], key_byte};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ps2_key <= '0;
		end else if (key_commit) begin
			ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
			// multi-byte keys that the plain rule gets wrong
			if (key_raw == PRTSCR_MAKE_SEQ) begin
				ps2_key[9:0] <= PRTSCR_MAKE_CODE;
			end else if (key_raw == PRTSCR_BREAK_SEQ) begin
				ps2_key[9:0] <= PRTSCR_BREAK_CODE;
			end else if (key_raw == PAUSE_MAKE_SEQ) begin
				ps2_key[9:0] <= PAUSE_MAKE_CODE;
			end
		end
	end

endmodule

// ==== src/file_loader.sv ====
/*
 * file transfer path, download direction only
 * first strobe of an fp_enable transaction is the command, the rest are arguments
 */

`timescale 1ns/100ps

module file_loader (
	input  logic                                 clk_sys,
	input  logic                                 rst,
	input  logic                                 io_strobe,
	input  logic                                 fp_enable,
	input  hps_io_pkg::io_word_t                 io_din,
	output logic                                 ioctl_download,
	output hps_io_pkg::io_word_t                 ioctl_index,
	output logic                                 ioctl_wr,
	output logic [hps_io_pkg::ADDR_W-1:0]        ioctl_addr,
	output logic [hps_io_pkg::DATA_W-1:0]        ioctl_dout
);

	import hps_io_pkg::*;

	io_word_t          cmd;
	logic              has_cmd;
	logic [1:0]        tx_cnt;
	logic [ADDR_W-1:0] addr;
	logic              wr;
	logic              arg_strobe;
	logic              tx_start;
	logic              data_wr;

	assign arg_strobe = fp_enable & io_strobe & has_cmd;
	assign tx_start   = arg_strobe & (cmd == FIO_FILE_TX) & (tx_cnt == 2'd0);
	assign data_wr    = arg_strobe & (cmd == FIO_FILE_TX_DAT) & ioctl_download;

	////////////////////
	// control

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			has_cmd        <= 1'b0;
			tx_cnt         <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
		end else begin
			// write strobe trails the address and data by one cycle
			ioctl_wr <= wr;
			wr       <= data_wr;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe && !has_cmd) begin
				has_cmd <= 1'b1;
				tx_cnt  <= '0;
			end else if (arg_strobe && cmd == FIO_FILE_TX && ~&tx_cnt) begin
				tx_cnt <= tx_cnt + 1'b1;
			end

			if (tx_start && io_din[7:0] != FIO_TX_UPLOAD) begin
				ioctl_download <= (io_din[7:0] != 8'h00);
			end
		end
	end

	////////////////////
	// command, index, address and data

	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe && !has_cmd) begin
			cmd <= io_din;
		end

		if (arg_strobe && cmd == FIO_FILE_INDEX) begin
			ioctl_index <= io_din;
		end

		if (tx_start && io_din[7:0] != FIO_TX_UPLOAD) begin
			if (io_din[7:0] != 8'h00) begin
				addr <= '0;
			end else if (ioctl_download) begin
				// leave the end address visible after the stop
				ioctl_addr <= addr;
			end
		end

		// start address words, low half then high bits
		if (arg_strobe && cmd == FIO_FILE_TX && tx_cnt == 2'd1) begin
			addr[15:0]       <= io_din;
			ioctl_addr[15:0] <= io_din;
		end
		if (arg_strobe && cmd == FIO_FILE_TX && tx_cnt == 2'd2) begin
			addr[ADDR_W-1:16]       <= io_din[ADDR_W-17:0];
			ioctl_addr[ADDR_W-1:16] <= io_din[ADDR_W-17:0];
		end

		if (data_wr) begin
			ioctl_addr <= addr;
			ioctl_dout <= io_din[DATA_W-1:0];
			addr       <= addr + 1'b1;
		end
	end

endmodule

// ==== src/hps_io_top.sv ====
/*
 * host command channel of the I/O hub
 * joins the user-I/O decoder, status request capture, key decoder and file loader
 */

`timescale 1ns/100ps

module hps_io_top (
	input  logic                                 clk_sys,
	input  logic                                 rst,

	// host bus
	input  logic                                 io_strobe,
	input  logic                                 io_enable,
	input  logic                                 fp_enable,
	input  hps_io_pkg::io_word_t                 io_din,
	output hps_io_pkg::io_word_t                 io_dout,
	output logic                                 io_wait,
	input  logic                                 ioctl_wait,

	// core status request
	input  logic                                 status_set,
	input  logic [hps_io_pkg::STATUS_W-1:0]      status_in,

	// user controls
	output logic [1:0]                           buttons,
	output logic                                 forced_scandoubler,
	output logic                                 direct_video,
	output logic [hps_io_pkg::JOY_W-1:0]         joystick_0,
	output logic [hps_io_pkg::JOY_W-1:0]         joystick_1,
	output logic [hps_io_pkg::STATUS_W-1:0]      status,
	output logic [hps_io_pkg::KEY_W-1:0]         ps2_key,

	// download stream
	output logic                                 ioctl_download,
	output hps_io_pkg::io_word_t                 ioctl_index,
	output logic                                 ioctl_wr,
	output logic [hps_io_pkg::ADDR_W-1:0]        ioctl_addr,
	output logic [hps_io_pkg::DATA_W-1:0]        ioctl_dout
);

	import hps_io_pkg::*;

	logic [CFG_W-1:0]     cfg;
	logic [REQ_CNT_W-1:0] req_count;
	logic [STATUS_W-1:0]  status_req;
	logic [7:0]           key_byte;
	logic                 key_shift;
	logic                 key_clear;
	logic                 key_commit;

	// the core has no buffering, so its wait goes straight back to the host
	assign io_wait = ioctl_wait;

	// bit 2, 3 and 5 belong to the video system outside this hub
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	uio_cmd_decoder i_uio_cmd_decoder (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.io_strobe  (io_strobe),
		.io_enable  (io_enable),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.req_count  (req_count),
		.status_req (status_req),
		.key_byte   (key_byte),
		.key_shift  (key_shift),
		.key_clear  (key_clear),
		.key_commit (key_commit)
	);

	status_request i_status_request (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.status_set (status_set),
		.status_in  (status_in),
		.req_count  (req_count),
		.status_req (status_req)
	);

	ps2_key_decoder i_ps2_key_decoder (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.key_byte   (key_byte),
		.key_shift  (key_shift),
		.key_clear  (key_clear),
		.key_commit (key_commit),
		.ps2_key    (ps2_key)
	);

	file_loader i_file_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== testbench/tb_hps_io_ref.svh ====
/*
 * expected-value functions and host bus tasks for the I/O hub testbench
 * included inside tb_hps_io after its signal declarations
 */

`ifndef TB_HPS_IO_REF_SVH
`define TB_HPS_IO_REF_SVH

////////////////////
// reference model

// hist holds the last four scan bytes, newest in the low byte
function automatic logic [10:0] key_event(input logic [10:0] prev, input logic [31:0] hist);
	logic       pressed;
	logic       ext;
	logic [9:0] low;
	pressed = (hist[15:8] != 8'hF0);
	if (pressed) begin
		ext = (hist[15:8] == 8'hE0);
	end else begin
		ext = (hist[23:16] == 8'hE0);
	end
	low = {pressed, ext, hist[7:0]};
	// print-screen make, print-screen break, pause make
	if (hist == 32'hE012E07C) begin
		low = 10'h37C;
	end else if (hist == 32'h7CE0F012) begin
		low = 10'h17C;
	end else if (hist == 32'hF014F077) begin
		low = 10'h377;
	end
	return {~prev[10], low};
endfunction

// word k of the 0x29 readback: tag and count first, then status lowest word first
function automatic io_word_t status_readback(input int k, input logic [3:0] count,
	input logic [63:0] word);
	io_word_t res;
	if (k == 0) begin
		res = {8'h00, 4'hA, count};
	end else begin
		res = 16'(word >> (16 * (k - 1)));
	end
	return res;
endfunction

////////////////////
// checks and bus access

task automatic check(input string name, input logic [63:0] got, input logic [63:0] want,
	inout int count);
	if (got !== want) begin
		count++;
		$display("Error: %s = %h, expected %h at %0t", name, got, want, $time);
	end
endtask

task automatic begin_tx(input logic file_tx);
	@(posedge clk_sys);
	if (file_tx) begin
		fp_enable <= 1'b1;
	end else begin
		io_enable <= 1'b1;
	end
endtask

// drops the enable and lets the commit and the readback clear settle
task automatic end_tx();
	@(posedge clk_sys);
	io_enable <= 1'b0;
	fp_enable <= 1'b0;
	repeat (2) @(posedge clk_sys);
	@(negedge clk_sys);
endtask

// one strobed word, rd is the registered readback after it
task automatic io_word(input io_word_t w, output io_word_t rd);
	@(posedge clk_sys);
	while (io_wait) begin
		@(posedge clk_sys);
	end
	io_strobe <= 1'b1;
	io_din    <= w;
	@(posedge clk_sys);
	io_strobe <= 1'b0;
	@(negedge clk_sys);
	rd = io_dout;
endtask

`endif

// ==== testbench/tb_hps_io.sv ====
/*
 * testbench for the host command channel
 * drives host bus transactions into hps_io_top and checks registers, key events,
 * status readback and the download write stream
 */

`timescale 1ns/100ps

module tb_hps_io;

	import hps_io_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int N_DATA      = 40;
	// register and keyboard transactions take under 70 words
	localparam int TOTAL_WORDS = 70 + N_DATA;
	localparam int WD_CYCLES   = 8 + TOTAL_WORDS * 4 + 200;

	logic                clk_sys = 1'b0;
	logic                rst;
	logic                io_strobe;
	logic                io_enable;
	logic                fp_enable;
	io_word_t            io_din;
	io_word_t            io_dout;
	logic                io_wait;
	logic                ioctl_wait;
	logic                status_set;
	logic [STATUS_W-1:0] status_in;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	logic [KEY_W-1:0]    ps2_key;
	logic                ioctl_download;
	io_word_t            ioctl_index;
	logic                ioctl_wr;
	logic [ADDR_W-1:0]   ioctl_addr;
	logic [DATA_W-1:0]   ioctl_dout;

	integer              seed;
	int                  errors;
	int                  wr_errors;
	int                  wr_count;
	int                  i;
	io_word_t            rd;
	io_word_t            word;
	logic [31:0]         rnd;
	logic [63:0]         wide;
	logic [3:0]          req_total;
	logic [10:0]         exp_key;
	logic [ADDR_W-1:0]   wr_start;
	logic [7:0]          exp_data[$];

	`include "tb_hps_io_ref.svh"

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	hps_io_top i_dut (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.ioctl_wait         (ioctl_wait),
		.status_set         (status_set),
		.status_in          (status_in),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	// keyboard transaction, seq holds n scan bytes with the first one highest
	task automatic send_keys(input logic [63:0] seq, input int n);
		logic [31:0] hist;
		logic [7:0]  b;
		io_word_t    kr;
		int          k;
		hist = '0;
		begin_tx(1'b0);
		io_word(CMD_KBD, kr);
		for (k = 0; k < n; k++) begin
			b = 8'(seq >> (8 * (n - 1 - k)));
			io_word({8'h00, b}, kr);
			hist = {hist[23:0], b};
		end
		end_tx();
		exp_key = key_event(exp_key, hist);
		check("ps2_key", 64'(ps2_key), 64'(exp_key), errors);
	endtask

	////////////////////
	// write stream comparison

	always @(negedge clk_sys) begin
		if (!rst && ioctl_wr) begin
			if (wr_count >= exp_data.size()) begin
				wr_errors++;
				$display("ioctl_wr pulsed with no data word outstanding at %0t", $time);
			end else begin
				check("ioctl_addr", 64'(ioctl_addr), 64'(wr_start + ADDR_W'(wr_count)), wr_errors);
				check("ioctl_dout", 64'(ioctl_dout), 64'(exp_data[wr_count]), wr_errors);
			end
			wr_count++;
		end
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("timeout, the run did not end within %0d clock cycles", WD_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// stimulus

	initial begin
		seed = 75449;
		errors = 0;
		wr_errors = 0;
		wr_count = 0;
		req_total = '0;
		exp_key = '0;
		wr_start = '0;
		rst = 1'b1;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;
		status_set = 1'b0;
		status_in = '0;
		repeat (8) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);

		check("ioctl_download", 64'(ioctl_download), 64'(0), errors);
		check("ioctl_wr", 64'(ioctl_wr), 64'(0), errors);
		check("ps2_key", 64'(ps2_key), 64'(0), errors);
		check("status", status, 64'(0), errors);
		check("joystick_0", 64'(joystick_0), 64'(0), errors);
		check("joystick_1", 64'(joystick_1), 64'(0), errors);
		check("io_dout", 64'(io_dout), 64'(0), errors);

		// core back-pressure reaches the host bus
		@(posedge clk_sys);
		ioctl_wait <= 1'b1;
		@(negedge clk_sys);
		check("io_wait", 64'(io_wait), 64'(1), errors);
		@(posedge clk_sys);
		ioctl_wait <= 1'b0;
		@(negedge clk_sys);
		check("io_wait", 64'(io_wait), 64'(0), errors);

		// configuration word and joysticks
		word = 16'($random(seed));
		begin_tx(1'b0);
		io_word(CMD_CFG, rd);
		io_word(word, rd);
		end_tx();
		check("buttons", 64'(buttons), 64'(word[1:0]), errors);
		check("forced_scandoubler", 64'(forced_scandoubler), 64'(word[4]), errors);
		check("direct_video", 64'(direct_video), 64'(word[10]), errors);
		rnd = $random(seed);
		begin_tx(1'b0);
		io_word(CMD_JOY0, rd);
		io_word(rnd[15:0], rd);
		io_word(rnd[31:16], rd);
		end_tx();
		check("joystick_0", 64'(joystick_0), 64'(rnd), errors);
		rnd = $random(seed);
		begin_tx(1'b0);
		io_word(CMD_JOY1, rd);
		io_word(rnd[15:0], rd);
		io_word(rnd[31:16], rd);
		end_tx();
		check("joystick_1", 64'(joystick_1), 64'(rnd), errors);

		// status write, lowest word first
		wide = {$random(seed), $random(seed)};
		begin_tx(1'b0);
		io_word(CMD_STATUS, rd);
		for (i = 0; i < 4; i++) begin
			io_word(16'(wide >> (16 * i)), rd);
		end
		end_tx();
		check("status", status, wide, errors);

		// several requests from the core, only the last word is kept
		for (i = 0; i < 3; i++) begin
			wide = {$random(seed), $random(seed)};
			@(posedge clk_sys);
			status_in  <= wide;
			status_set <= 1'b1;
			repeat (2) @(posedge clk_sys);
			status_set <= 1'b0;
			req_total = req_total + 4'd1;
			repeat (2) @(posedge clk_sys);
		end
		begin_tx(1'b0);
		for (i = 0; i < 5; i++) begin
			io_word((i == 0) ? CMD_STATUS_REQ : 16'h0000, rd);
			check("io_dout", 64'(rd), 64'(status_readback(i, req_total, wide)), errors);
		end
		end_tx();
		check("io_dout", 64'(io_dout), 64'(0), errors);

		// keyboard events
		send_keys(64'h1C, 1);
		send_keys(64'hE075, 2);
		send_keys(64'hF01C, 2);
		send_keys(64'hE0F075, 3);
		send_keys(64'hE012E07C, 4);
		send_keys(64'hE0F07CE0F012, 6);
		send_keys(64'hE11477E1F014F077, 8);
		// a skip word voids the whole transaction
		begin_tx(1'b0);
		io_word(CMD_KBD, rd);
		io_word(16'hFF12, rd);
		io_word(16'h001C, rd);
		end_tx();
		check("ps2_key", 64'(ps2_key), 64'(exp_key), errors);

		// download: index, start with address, data, stop
		word = 16'($random(seed));
		begin_tx(1'b1);
		io_word(FIO_FILE_INDEX, rd);
		io_word(word, rd);
		end_tx();
		check("ioctl_index", 64'(ioctl_index), 64'(word), errors);
		rnd = $random(seed);
		wr_start = rnd[ADDR_W-1:0];
		begin_tx(1'b1);
		io_word(FIO_FILE_TX, rd);
		io_word(16'h00FF, rd);
		io_word(wr_start[15:0], rd);
		io_word({5'b00000, wr_start[ADDR_W-1:16]}, rd);
		end_tx();
		check("ioctl_download", 64'(ioctl_download), 64'(1), errors);
		begin_tx(1'b1);
		io_word(FIO_FILE_TX_DAT, rd);
		for (i = 0; i < N_DATA; i++) begin
			word = 16'($random(seed));
			exp_data.push_back(word[7:0]);
			io_word(word, rd);
		end
		end_tx();
		begin_tx(1'b1);
		io_word(FIO_FILE_TX, rd);
		io_word(16'h0000, rd);
		end_tx();
		check("ioctl_download", 64'(ioctl_download), 64'(0), errors);
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("ioctl_wr count", 64'(wr_count), 64'(N_DATA), errors);

		$display("errors: %0d in value checks, %0d in the write stream", errors, wr_errors);
		if (errors == 0 && wr_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+testbench
src/hps_io_pkg.sv
src/uio_cmd_decoder.sv
src/status_request.sv
src/ps2_key_decoder.sv
src/file_loader.sv
src/hps_io_top.sv
testbench/tb_hps_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module tb_hps_io \
	-o sim_tb > build.log 2>&1 || { cat build.log; echo "compile failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" || { echo "result: no pass line"; exit 1; }
